// ==== Makefile ====
TOP := io_predication_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f $(wildcard rtl/*.sv bench/*.sv)
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f

lint:
	verilator --lint-only -Wall --timing --top-module io_predication_top -f sources.f

clean:
	rm -rf obj_dir

// ==== bench/io_predication_tb.sv ====
// Inputs change at rising edges and outputs are checked at falling edges.
`timescale 1ns/10ps

module io_predication_tb;

    import io_map_pkg::*;
    import instr_pkg::*;

    logic                   clock;
    logic                   rst_n;
    logic [INSTR_WIDTH-1:0] instr_in;
    logic                   instr_valid;
    logic [PORT_COUNT-1:0]  read_ef_a;
    logic [PORT_COUNT-1:0]  read_ef_b;
    logic [PORT_COUNT-1:0]  write_ef_a;
    logic [PORT_COUNT-1:0]  write_ef_b;
    logic                   stall;
    logic                   issue;
    logic                   io_ready;
    logic [PORT_COUNT-1:0]  io_rden_a;
    logic [PORT_COUNT-1:0]  io_rden_b;
    logic [PORT_COUNT-1:0]  io_wren_a;
    logic [PORT_COUNT-1:0]  io_wren_b;
    logic                   read_addr_is_io_a;
    logic                   read_addr_is_io_b;
    logic                   write_addr_is_io_a;
    logic                   write_addr_is_io_b;
    integer                 seed;

    io_predication_top dut_i (
        .clock              (clock),
        .rst_n              (rst_n),
        .instr_in           (instr_in),
        .instr_valid        (instr_valid),
        .read_ef_a          (read_ef_a),
        .read_ef_b          (read_ef_b),
        .write_ef_a         (write_ef_a),
        .write_ef_b         (write_ef_b),
        .stall              (stall),
        .issue              (issue),
        .io_ready           (io_ready),
        .io_rden_a          (io_rden_a),
        .io_rden_b          (io_rden_b),
        .io_wren_a          (io_wren_a),
        .io_wren_b          (io_wren_b),
        .read_addr_is_io_a  (read_addr_is_io_a),
        .read_addr_is_io_b  (read_addr_is_io_b),
        .write_addr_is_io_a (write_addr_is_io_a),
        .write_addr_is_io_b (write_addr_is_io_b)
    );

    always #5 clock = ~clock;  // 10 ns period.

    function automatic logic [INSTR_WIDTH-1:0] make_word(
        input op_e         op,
        input logic [11:0] d,
        input logic [10:0] a,
        input logic [10:0] b
    );
        logic [INSTR_WIDTH-1:0] word;
        word                = '0;
        word[OP_MSB:OP_LSB] = op;
        word[D_MSB:D_LSB]   = d;
        word[A_MSB:A_LSB]   = a;
        word[B_MSB:B_LSB]   = b;
        return word;
    endfunction

    function automatic logic [3:0] port_onehot(input logic en, input logic [1:0] port);
        return en ? (4'b0001 << port) : 4'b0000;
    endfunction

    // Reference model returning {ready, four is_io flags, rden_a, rden_b, wren_a, wren_b}.
    function automatic logic [20:0] expected_outputs(
        input logic [INSTR_WIDTH-1:0] word,
        input logic [3:0]             ref_a,
        input logic [3:0]             ref_b,
        input logic [3:0]             wef_a,
        input logic [3:0]             wef_b
    );
        logic [1:0]  op;
        logic [11:0] d;
        logic [11:0] d_a;
        logic [11:0] d_b;
        logic [10:0] ra;
        logic [10:0] rb;
        logic        on;
        logic        io_ra;
        logic        io_rb;
        logic        io_wa;
        logic        io_wb;
        logic        ready;
        op  = word[OP_MSB:OP_LSB];
        d   = word[D_MSB:D_LSB];
        ra  = word[A_MSB:A_LSB];
        rb  = word[B_MSB:B_LSB];
        on  = (op == 2'd1) || (op == 2'd2);  // Nop and reserved touch nothing.
        d_a = d;
        d_b = d;
        if (op == 2'd2 && d >= 12'h600 && d <= 12'h7FF) begin
            d_a = d - 12'h400;  // Upper half of B lands in A.
            d_b = 12'hFFF;
        end
        io_ra = on && ra >= 11'h3FC && ra <= 11'h3FF;
        io_rb = on && rb >= 11'h7FC;
        io_wa = on && d_a >= 12'h3FC && d_a <= 12'h3FF;
        io_wb = on && d_b >= 12'h7FC && d_b <= 12'h7FF;
        ready = (!io_ra || ref_a[ra[1:0]]) && (!io_rb || ref_b[rb[1:0]]) &&
                (!io_wa || wef_a[d_a[1:0]]) && (!io_wb || wef_b[d_b[1:0]]);
        return {ready, io_ra, io_rb, io_wa, io_wb,
                port_onehot(io_ra && ready, ra[1:0]), port_onehot(io_rb && ready, rb[1:0]),
                port_onehot(io_wa && ready, d_a[1:0]), port_onehot(io_wb && ready, d_b[1:0])};
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "Value mismatch on %s.", name);
        end
    endtask

    task automatic expect_idle();
        check("stall", stall, 0);
        check("issue", issue, 0);
        check("io_ready", io_ready, 1);
        check("is_io flags", {read_addr_is_io_a, read_addr_is_io_b,
                              write_addr_is_io_a, write_addr_is_io_b}, 0);
        check("port enables", {io_rden_a, io_rden_b, io_wren_a, io_wren_b}, 0);
    endtask

    task automatic compare_with_model(input logic [INSTR_WIDTH-1:0] word);
        logic [20:0] exp;
        exp = expected_outputs(word, read_ef_a, read_ef_b, write_ef_a, write_ef_b);
        check("io_ready", io_ready, exp[20]);
        check("issue", issue, exp[20]);
        check("stall", stall, !exp[20]);
        check("read_addr_is_io_a", read_addr_is_io_a, exp[19]);
        check("read_addr_is_io_b", read_addr_is_io_b, exp[18]);
        check("write_addr_is_io_a", write_addr_is_io_a, exp[17]);
        check("write_addr_is_io_b", write_addr_is_io_b, exp[16]);
        check("io_rden_a", io_rden_a, exp[15:12]);
        check("io_rden_b", io_rden_b, exp[11:8]);
        check("io_wren_a", io_wren_a, exp[7:4]);
        check("io_wren_b", io_wren_b, exp[3:0]);
    endtask

    task automatic drive_flags(input logic [3:0] ra, input logic [3:0] rb,
                               input logic [3:0] wa, input logic [3:0] wb);
        @(posedge clock);
        read_ef_a  <= ra;
        read_ef_b  <= rb;
        write_ef_a <= wa;
        write_ef_b <= wb;
    endtask

    // Offers one word; returns just after the edge that accepts it.
    task automatic offer_instr(input logic [INSTR_WIDTH-1:0] word);
        @(posedge clock);
        instr_in    <= word;
        instr_valid <= 1'b1;
        @(negedge clock);
        expect_idle();  // Buffer is empty so nothing may fire.
        @(posedge clock);
        instr_valid <= 1'b0;
    endtask

    task automatic await_issue(input logic [INSTR_WIDTH-1:0] word, input logic grow,
                               input int limit, output int latency);
        logic done;
        done    = 1'b0;
        latency = 0;
        while (!done) begin
            @(negedge clock);
            latency++;
            compare_with_model(word);
            if (issue) begin
                done = 1'b1;
            end else if (latency >= limit) begin
                $display("Instruction did not issue within %0d cycles", limit);
                $display("Some tests failed");
                $fatal(1, "Timeout waiting for issue.");
            end else begin
                @(posedge clock);
                if (grow) begin  // Ports become ready at random.
                    read_ef_a  <= read_ef_a | 4'($random(seed));
                    read_ef_b  <= read_ef_b | 4'($random(seed));
                    write_ef_a <= write_ef_a | 4'($random(seed));
                    write_ef_b <= write_ef_b | 4'($random(seed));
                end
            end
        end
    endtask

    task automatic execute_instr(input logic [INSTR_WIDTH-1:0] word, input logic grow,
                                 input int limit, output int latency);
        offer_instr(word);
        await_issue(word, grow, limit, latency);
    endtask

    task automatic hold_stalled(input logic [INSTR_WIDTH-1:0] word, input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            compare_with_model(word);
            check("stall", stall, 1);
        end
    endtask

    task automatic reset_state();
        @(posedge clock);
        instr_in    <= make_word(op_alu, 12'h020, 11'h010, 11'h410);
        instr_valid <= 1'b1;  // Offered during reset and never taken.
        repeat (10) begin
            @(negedge clock);
            expect_idle();
        end
        @(posedge clock);
        rst_n       <= 1'b1;
        instr_valid <= 1'b0;
        @(negedge clock);
        expect_idle();
    endtask

    task automatic plain_instr();
        int latency;
        drive_flags(4'hF, 4'hF, 4'hF, 4'hF);
        execute_instr(make_word(op_alu, 12'h020, 11'h010, 11'h410), 1'b0, 5, latency);
        check("issue latency", latency, 1);
        check("is_io flags", {read_addr_is_io_a, read_addr_is_io_b,
                              write_addr_is_io_a, write_addr_is_io_b}, 0);
        execute_instr(make_word(op_nop, 12'h7FC, 11'h3FC, 11'h7FC), 1'b0, 5, latency);
        check("issue latency", latency, 1);
        check("port enables", {io_rden_a, io_rden_b, io_wren_a, io_wren_b}, 0);
    endtask

    task automatic io_read_backpressure();
        logic [INSTR_WIDTH-1:0] word;
        int                     latency;
        word = make_word(op_alu, 12'h020, 11'h3FE, 11'h410);  // Port 2 of A.
        drive_flags(4'b1011, 4'hF, 4'hF, 4'hF);
        offer_instr(word);
        hold_stalled(word, 20);
        check("read_addr_is_io_a", read_addr_is_io_a, 1);
        drive_flags(4'hF, 4'hF, 4'hF, 4'hF);
        await_issue(word, 1'b0, 5, latency);
        check("io_rden_a", io_rden_a, 4'b0100);
    endtask

    task automatic io_write_all_ready();
        logic [INSTR_WIDTH-1:0] word;
        int                     latency;
        word = make_word(op_alu, 12'h7FD, 11'h010, 11'h7FF);  // Write port 1, read port 3 of B.
        drive_flags(4'hF, 4'hF, 4'hF, 4'b1101);
        offer_instr(word);
        hold_stalled(word, 5);
        drive_flags(4'hF, 4'b0111, 4'hF, 4'hF);
        hold_stalled(word, 5);
        drive_flags(4'hF, 4'hF, 4'hF, 4'hF);
        await_issue(word, 1'b0, 5, latency);
        check("io_wren_b", io_wren_b, 4'b0010);
        check("io_rden_b", io_rden_b, 4'b1000);
    endtask

    task automatic split_mode();
        int latency;
        drive_flags(4'hF, 4'hF, 4'hF, 4'hF);
        execute_instr(make_word(op_alu, 12'h7FC, 11'h010, 11'h410), 1'b0, 5, latency);
        check("write_addr_is_io_b", write_addr_is_io_b, 1);
        execute_instr(make_word(op_alu_split, 12'h7FC, 11'h010, 11'h410), 1'b0, 5, latency);
        check("write_addr_is_io_a", write_addr_is_io_a, 1);
        check("write_addr_is_io_b", write_addr_is_io_b, 0);
        check("io_wren_a", io_wren_a, 4'b0001);
        execute_instr(make_word(op_alu_split, 12'h500, 11'h010, 11'h410), 1'b0, 5, latency);
        check("write is_io flags", {write_addr_is_io_a, write_addr_is_io_b}, 0);
    endtask

    task automatic random_instrs();
        logic [31:0] r;
        logic [31:0] q;
        logic [31:0] f;
        logic [11:0] d;
        logic [10:0] ra;
        logic [10:0] rb;
        int          i;
        int          latency;
        for (i = 0; i < 200; i++) begin
            r = $random(seed);
            q = $random(seed);
            f = $random(seed);
            case (r[1:0])  // Most write addresses near a port window.
                2'd0: d = 12'h3FC | 12'(r[5:4]);
                2'd1: d = 12'h7FC | 12'(r[5:4]);
                2'd2: d = 12'h600 | 12'(r[13:4]);
                default: d = r[27:16];
            endcase
            ra = r[6] ? (11'h3FC | 11'(r[8:7])) : q[10:0];
            rb = r[9] ? (11'h7FC | 11'(r[11:10])) : q[21:11];
            drive_flags(f[3:0], f[7:4], f[11:8], f[15:12]);
            execute_instr(make_word(op_e'(r[31:30]), d, ra, rb), 1'b1, 50, latency);
        end
    endtask

    initial begin
        clock       = 1'b0;
        rst_n       = 1'b0;
        instr_in    = '0;
        instr_valid = 1'b0;
        read_ef_a   = 4'hF;
        read_ef_b   = 4'hF;
        write_ef_a  = 4'hF;
        write_ef_b  = 4'hF;
        seed        = 32'h87b68eb2;
        reset_state();
        plain_instr();
        io_read_backpressure();
        io_write_all_ready();
        split_mode();
        random_instrs();
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== rtl/datapath_io_predication.sv ====
// Combinational on the held entry; A takes the upper half of a split D and B the lower.
`timescale 1ns/10ps

module datapath_io_predication (
    input  logic [io_map_pkg::READ_ADDR_WIDTH-1:0]  read_addr_a,
    input  logic [io_map_pkg::READ_ADDR_WIDTH-1:0]  read_addr_b,
    input  logic [io_map_pkg::WRITE_ADDR_WIDTH-1:0] write_addr_d,
    input  logic                                    reads_on,
    input  logic                                    writes_on,
    input  logic                                    split,
    input  logic                                    held_valid,
    input  logic [io_map_pkg::PORT_COUNT-1:0]       read_ef_a,
    input  logic [io_map_pkg::PORT_COUNT-1:0]       read_ef_b,
    input  logic [io_map_pkg::PORT_COUNT-1:0]       write_ef_a,
    input  logic [io_map_pkg::PORT_COUNT-1:0]       write_ef_b,
    output logic [io_map_pkg::PORT_COUNT-1:0]       io_rden_a,
    output logic [io_map_pkg::PORT_COUNT-1:0]       io_rden_b,
    output logic [io_map_pkg::PORT_COUNT-1:0]       io_wren_a,
    output logic [io_map_pkg::PORT_COUNT-1:0]       io_wren_b,
    output logic                                    read_addr_is_io_a,
    output logic                                    read_addr_is_io_b,
    output logic                                    write_addr_is_io_a,
    output logic                                    write_addr_is_io_b,
    output logic                                    io_ready
);

    import io_map_pkg::*;
    import instr_pkg::*;

    logic [WRITE_ADDR_WIDTH-1:0] write_addr_a;
    logic [WRITE_ADDR_WIDTH-1:0] write_addr_b;
    logic                        read_enable_a;
    logic                        read_enable_b;
    logic                        write_enable_a;
    logic                        write_enable_b;
    logic [MEM_ADDR_WIDTH-1:0]   read_local_a;
    logic [MEM_ADDR_WIDTH-1:0]   read_local_b;
    logic [MEM_ADDR_WIDTH-1:0]   write_local_a;
    logic [MEM_ADDR_WIDTH-1:0]   write_local_b;
    logic                        read_ef_masked_a;
    logic                        read_ef_masked_b;
    logic                        write_ef_masked_a;
    logic                        write_ef_masked_b;

    write_addr_split #(.HALF(half_upper)) split_a_i (
        .split                 (split),
        .write_addr            (write_addr_d),
        .write_addr_translated (write_addr_a)
    );

    write_addr_split #(.HALF(half_lower)) split_b_i (
        .split                 (split),
        .write_addr            (write_addr_d),
        .write_addr_translated (write_addr_b)
    );

    mem_range_check #(.BASE(MEM_A_BASE), .BOUND(MEM_A_BOUND)) range_a_i (
        .read_addr    (read_addr_a),
        .write_addr   (write_addr_a),
        .reads_on     (reads_on),
        .writes_on    (writes_on),
        .read_enable  (read_enable_a),
        .write_enable (write_enable_a)
    );

    mem_range_check #(.BASE(MEM_B_BASE), .BOUND(MEM_B_BOUND)) range_b_i (
        .read_addr    (read_addr_b),
        .write_addr   (write_addr_b),
        .reads_on     (reads_on),
        .writes_on    (writes_on),
        .read_enable  (read_enable_b),
        .write_enable (write_enable_b)
    );

    // Local addresses inside each memory.
    assign read_local_a  = MEM_ADDR_WIDTH'(WRITE_ADDR_WIDTH'(read_addr_a) - MEM_A_BASE);
    assign read_local_b  = MEM_ADDR_WIDTH'(WRITE_ADDR_WIDTH'(read_addr_b) - MEM_B_BASE);
    assign write_local_a = MEM_ADDR_WIDTH'(write_addr_a - MEM_A_BASE);
    assign write_local_b = MEM_ADDR_WIDTH'(write_addr_b - MEM_B_BASE);

    mem_io_predication io_a_i (
        .read_enable      (read_enable_a),
        .write_enable     (write_enable_a),
        .read_addr        (read_local_a),
        .write_addr       (write_local_a),
        .read_ef          (read_ef_a),
        .write_ef         (write_ef_a),
        .held_valid       (held_valid),
        .io_ready         (io_ready),
        .read_ef_masked   (read_ef_masked_a),
        .write_ef_masked  (write_ef_masked_a),
        .read_addr_is_io  (read_addr_is_io_a),
        .write_addr_is_io (write_addr_is_io_a),
        .io_rden          (io_rden_a),
        .io_wren          (io_wren_a)
    );

    mem_io_predication io_b_i (
        .read_enable      (read_enable_b),
        .write_enable     (write_enable_b),
        .read_addr        (read_local_b),
        .write_addr       (write_local_b),
        .read_ef          (read_ef_b),
        .write_ef         (write_ef_b),
        .held_valid       (held_valid),
        .io_ready         (io_ready),
        .read_ef_masked   (read_ef_masked_b),
        .write_ef_masked  (write_ef_masked_b),
        .read_addr_is_io  (read_addr_is_io_b),
        .write_addr_is_io (write_addr_is_io_b),
        .io_rden          (io_rden_b),
        .io_wren          (io_wren_b)
    );

    // Every port the instruction touches must be ready.
    assign io_ready = read_ef_masked_a & write_ef_masked_a & read_ef_masked_b & write_ef_masked_b;

endmodule

// ==== rtl/instr_field_decode.sv ====
// Purely combinational; fields are passed through unchanged and only the enables depend on opcode.
`timescale 1ns/10ps

module instr_field_decode (
    input  logic [instr_pkg::INSTR_WIDTH-1:0]       instr_in,
    output logic [io_map_pkg::READ_ADDR_WIDTH-1:0]  read_addr_a,
    output logic [io_map_pkg::READ_ADDR_WIDTH-1:0]  read_addr_b,
    output logic [io_map_pkg::WRITE_ADDR_WIDTH-1:0] write_addr_d,
    output logic                                    reads_on,
    output logic                                    writes_on,
    output logic                                    split
);

    import instr_pkg::*;

    op_e opcode;

    assign opcode       = op_e'(instr_in[OP_MSB:OP_LSB]);
    assign write_addr_d = instr_in[D_MSB:D_LSB];
    assign read_addr_a  = instr_in[A_MSB:A_LSB];
    assign read_addr_b  = instr_in[B_MSB:B_LSB];

    always_comb begin
        reads_on  = 1'b0;
        writes_on = 1'b0;
        split     = 1'b0;
        case (opcode)
            op_alu: begin
                reads_on  = 1'b1;
                writes_on = 1'b1;
            end
            op_alu_split: begin
                reads_on  = 1'b1;
                writes_on = 1'b1;
                split     = 1'b1;  // Only opcode that redirects B's upper half.
            end
            op_nop, op_rsvd: begin
                reads_on  = 1'b0;
                writes_on = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/instr_pkg.sv ====
// Instruction word format; opcode code 3 is reserved and behaves as a nop.
package instr_pkg;

    localparam int INSTR_WIDTH = 36;

    // Field positions inside the instruction word.
    localparam int OP_MSB = 35;
    localparam int OP_LSB = 34;
    localparam int D_MSB  = 33;
    localparam int D_LSB  = 22;
    localparam int A_MSB  = 21;
    localparam int A_LSB  = 11;
    localparam int B_MSB  = 10;
    localparam int B_LSB  = 0;

    typedef enum logic [1:0] {
        op_nop       = 2'd0,  // No read, no write.
        op_alu       = 2'd1,
        op_alu_split = 2'd2,  // Write window of B split with A.
        op_rsvd      = 2'd3
    } op_e;

    typedef enum logic {
        half_lower = 1'b0,
        half_upper = 1'b1
    } half_e;

endpackage

// ==== rtl/instr_replay_buffer.sv ====
// One-entry buffer; the source must hold instr_in and instr_valid steady while stall is high.
`timescale 1ns/10ps

module instr_replay_buffer (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  logic                                    instr_valid,
    input  logic [io_map_pkg::READ_ADDR_WIDTH-1:0]  read_addr_a,
    input  logic [io_map_pkg::READ_ADDR_WIDTH-1:0]  read_addr_b,
    input  logic [io_map_pkg::WRITE_ADDR_WIDTH-1:0] write_addr_d,
    input  logic                                    reads_on,
    input  logic                                    writes_on,
    input  logic                                    split,
    input  logic                                    io_ready,
    output logic [io_map_pkg::READ_ADDR_WIDTH-1:0]  held_read_addr_a,
    output logic [io_map_pkg::READ_ADDR_WIDTH-1:0]  held_read_addr_b,
    output logic [io_map_pkg::WRITE_ADDR_WIDTH-1:0] held_write_addr_d,
    output logic                                    held_reads_on,
    output logic                                    held_writes_on,
    output logic                                    held_split,
    output logic                                    held_valid,
    output logic                                    stall,
    output logic                                    issue
);

    logic load;

    assign stall = held_valid & ~io_ready;  // Replay the entry next cycle.
    assign issue = held_valid & io_ready;
    assign load  = instr_valid & ~stall;

    // Empty or issuing, so take whatever the source offers.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            held_valid     <= 1'b0;
            held_reads_on  <= 1'b0;
            held_writes_on <= 1'b0;
        end else if (!stall) begin
            held_valid     <= instr_valid;
            held_reads_on  <= instr_valid & reads_on;   // Low while empty.
            held_writes_on <= instr_valid & writes_on;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            held_read_addr_a  <= read_addr_a;
            held_read_addr_b  <= read_addr_b;
            held_write_addr_d <= write_addr_d;
            held_split        <= split;
        end
    end

endmodule

// ==== rtl/io_map_pkg.sv ====
// Fixed address map of data memories A and B. Write addresses from 0x800 up enable nothing.
package io_map_pkg;

    localparam int READ_ADDR_WIDTH  = 11;  // Shared read space.
    localparam int WRITE_ADDR_WIDTH = 12;  // Shared write space.
    localparam int MEM_ADDR_WIDTH   = 10;  // Local address inside one memory.

    // Memory A and B ranges, identical in the read and write spaces.
    localparam logic [WRITE_ADDR_WIDTH-1:0] MEM_A_BASE  = 12'h000;
    localparam logic [WRITE_ADDR_WIDTH-1:0] MEM_A_BOUND = 12'h3FF;
    localparam logic [WRITE_ADDR_WIDTH-1:0] MEM_B_BASE  = 12'h400;
    localparam logic [WRITE_ADDR_WIDTH-1:0] MEM_B_BOUND = 12'h7FF;

    localparam logic [WRITE_ADDR_WIDTH-1:0] SPLIT_BASE      = 12'h600;  // Upper half of B.
    localparam logic [WRITE_ADDR_WIDTH-1:0] SPLIT_OFFSET    = 12'h400;  // Lands in A 0x200-0x3FF.
    localparam logic [WRITE_ADDR_WIDTH-1:0] NULL_WRITE_ADDR = 12'hFFF;  // Outside every memory.

    localparam int PORT_COUNT      = 4;
    localparam int PORT_ADDR_WIDTH = 2;
    localparam logic [MEM_ADDR_WIDTH-1:0] PORT_BASE_ADDR = 10'h3FC;  // Ports 0-3 at the top.

endpackage

// ==== rtl/io_predication_top.sv ====
// Plain stall level and issue pulse with no handshake; the source holds its word while stalled.
`timescale 1ns/10ps

module io_predication_top (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic [instr_pkg::INSTR_WIDTH-1:0]   instr_in,
    input  logic                                instr_valid,
    input  logic [io_map_pkg::PORT_COUNT-1:0]   read_ef_a,
    input  logic [io_map_pkg::PORT_COUNT-1:0]   read_ef_b,
    input  logic [io_map_pkg::PORT_COUNT-1:0]   write_ef_a,
    input  logic [io_map_pkg::PORT_COUNT-1:0]   write_ef_b,
    output logic                                stall,
    output logic                                issue,
    output logic                                io_ready,
    output logic [io_map_pkg::PORT_COUNT-1:0]   io_rden_a,
    output logic [io_map_pkg::PORT_COUNT-1:0]   io_rden_b,
    output logic [io_map_pkg::PORT_COUNT-1:0]   io_wren_a,
    output logic [io_map_pkg::PORT_COUNT-1:0]   io_wren_b,
    output logic                                read_addr_is_io_a,
    output logic                                read_addr_is_io_b,
    output logic                                write_addr_is_io_a,
    output logic                                write_addr_is_io_b
);

    import io_map_pkg::*;

    logic [READ_ADDR_WIDTH-1:0]  read_addr_a;
    logic [READ_ADDR_WIDTH-1:0]  read_addr_b;
    logic [WRITE_ADDR_WIDTH-1:0] write_addr_d;
    logic                        reads_on;
    logic                        writes_on;
    logic                        split;
    logic [READ_ADDR_WIDTH-1:0]  held_read_addr_a;
    logic [READ_ADDR_WIDTH-1:0]  held_read_addr_b;
    logic [WRITE_ADDR_WIDTH-1:0] held_write_addr_d;
    logic                        held_reads_on;
    logic                        held_writes_on;
    logic                        held_split;
    logic                        held_valid;

    instr_field_decode decode_i (
        .instr_in     (instr_in),
        .read_addr_a  (read_addr_a),
        .read_addr_b  (read_addr_b),
        .write_addr_d (write_addr_d),
        .reads_on     (reads_on),
        .writes_on    (writes_on),
        .split        (split)
    );

    instr_replay_buffer buffer_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .instr_valid       (instr_valid),
        .read_addr_a       (read_addr_a),
        .read_addr_b       (read_addr_b),
        .write_addr_d      (write_addr_d),
        .reads_on          (reads_on),
        .writes_on         (writes_on),
        .split             (split),
        .io_ready          (io_ready),
        .held_read_addr_a  (held_read_addr_a),
        .held_read_addr_b  (held_read_addr_b),
        .held_write_addr_d (held_write_addr_d),
        .held_reads_on     (held_reads_on),
        .held_writes_on    (held_writes_on),
        .held_split        (held_split),
        .held_valid        (held_valid),
        .stall             (stall),
        .issue             (issue)
    );

    datapath_io_predication predication_i (
        .read_addr_a        (held_read_addr_a),
        .read_addr_b        (held_read_addr_b),
        .write_addr_d       (held_write_addr_d),
        .reads_on           (held_reads_on),
        .writes_on          (held_writes_on),
        .split              (held_split),
        .held_valid         (held_valid),
        .read_ef_a          (read_ef_a),
        .read_ef_b          (read_ef_b),
        .write_ef_a         (write_ef_a),
        .write_ef_b         (write_ef_b),
        .io_rden_a          (io_rden_a),
        .io_rden_b          (io_rden_b),
        .io_wren_a          (io_wren_a),
        .io_wren_b          (io_wren_b),
        .read_addr_is_io_a  (read_addr_is_io_a),
        .read_addr_is_io_b  (read_addr_is_io_b),
        .write_addr_is_io_a (write_addr_is_io_a),
        .write_addr_is_io_b (write_addr_is_io_b),
        .io_ready           (io_ready)
    );

endmodule

// ==== rtl/mem_io_predication.sv ====
// I/O port logic of one memory; read_ef means data present and write_ef means space free.
`timescale 1ns/10ps

module mem_io_predication (
    input  logic                                  read_enable,
    input  logic                                  write_enable,
    input  logic [io_map_pkg::MEM_ADDR_WIDTH-1:0] read_addr,
    input  logic [io_map_pkg::MEM_ADDR_WIDTH-1:0] write_addr,
    input  logic [io_map_pkg::PORT_COUNT-1:0]     read_ef,
    input  logic [io_map_pkg::PORT_COUNT-1:0]     write_ef,
    input  logic                                  held_valid,
    input  logic                                  io_ready,
    output logic                                  read_ef_masked,
    output logic                                  write_ef_masked,
    output logic                                  read_addr_is_io,
    output logic                                  write_addr_is_io,
    output logic [io_map_pkg::PORT_COUNT-1:0]     io_rden,
    output logic [io_map_pkg::PORT_COUNT-1:0]     io_wren
);

    import io_map_pkg::*;

    logic [PORT_ADDR_WIDTH-1:0] read_port;
    logic [PORT_ADDR_WIDTH-1:0] write_port;
    logic                       fire;

    assign read_port  = read_addr[PORT_ADDR_WIDTH-1:0];
    assign write_port = write_addr[PORT_ADDR_WIDTH-1:0];

    assign read_addr_is_io  = read_enable && (read_addr >= PORT_BASE_ADDR);
    assign write_addr_is_io = write_enable && (write_addr >= PORT_BASE_ADDR);

    // Non-I/O accesses never hold up the instruction.
    assign read_ef_masked  = read_addr_is_io ? read_ef[read_port] : 1'b1;
    assign write_ef_masked = write_addr_is_io ? write_ef[write_port] : 1'b1;

    assign fire = held_valid & io_ready;  // Same cycle as issue.

    assign io_rden = (read_addr_is_io && fire) ? PORT_COUNT'(1) << read_port : '0;
    assign io_wren = (write_addr_is_io && fire) ? PORT_COUNT'(1) << write_port : '0;

endmodule

// ==== rtl/mem_range_check.sv ====
// Read and write enables of one memory; BASE and BOUND apply to both address spaces.
`timescale 1ns/10ps

module mem_range_check #(
    parameter logic [io_map_pkg::WRITE_ADDR_WIDTH-1:0] BASE  = '0,
    parameter logic [io_map_pkg::WRITE_ADDR_WIDTH-1:0] BOUND = '0
) (
    input  logic [io_map_pkg::READ_ADDR_WIDTH-1:0]  read_addr,
    input  logic [io_map_pkg::WRITE_ADDR_WIDTH-1:0] write_addr,
    input  logic                                    reads_on,
    input  logic                                    writes_on,
    output logic                                    read_enable,
    output logic                                    write_enable
);

    import io_map_pkg::*;

    logic [WRITE_ADDR_WIDTH-1:0] read_addr_ext;

    assign read_addr_ext = WRITE_ADDR_WIDTH'(read_addr);  // Compare at write width.

    assign read_enable  = reads_on && (read_addr_ext >= BASE) && (read_addr_ext <= BOUND);
    assign write_enable = writes_on && (write_addr >= BASE) && (write_addr <= BOUND);

endmodule

// ==== rtl/write_addr_split.sv ====
// In split mode the upper instance remaps D 0x600-0x7FF into A and the lower one masks it out.
`timescale 1ns/10ps

module write_addr_split #(
    parameter instr_pkg::half_e HALF = instr_pkg::half_upper
) (
    input  logic                                    split,
    input  logic [io_map_pkg::WRITE_ADDR_WIDTH-1:0] write_addr,
    output logic [io_map_pkg::WRITE_ADDR_WIDTH-1:0] write_addr_translated
);

    import io_map_pkg::*;
    import instr_pkg::*;

    logic in_split_window;

    assign in_split_window = (write_addr >= SPLIT_BASE) && (write_addr <= MEM_B_BOUND);

    always_comb begin
        write_addr_translated = write_addr;
        if (split && in_split_window) begin
            if (HALF == half_upper) begin
                write_addr_translated = write_addr - SPLIT_OFFSET;  // Into A 0x200-0x3FF.
            end else begin
                write_addr_translated = NULL_WRITE_ADDR;  // No memory claims it.
            end
        end
    end

endmodule

// ==== sources.f ====
rtl/io_map_pkg.sv
rtl/instr_pkg.sv
rtl/instr_field_decode.sv
rtl/instr_replay_buffer.sv
rtl/write_addr_split.sv
rtl/mem_range_check.sv
rtl/mem_io_predication.sv
rtl/datapath_io_predication.sv
rtl/io_predication_top.sv
bench/io_predication_tb.sv
